// File: sim.f
hw/sysctl_pkg.sv
hw/sysctl_decode.sv
hw/sysctl_regs.sv
hw/tick_timer.sv
hw/irq_ctrl.sv
hw/resp_merge.sv
hw/sysctl_top.sv
test/tb_sysctl.sv

// File: run_sim.sh
#!/bin/sh
# build and run the system control testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing -Wno-fatal -f sim.f --top-module tb_sysctl -Mdir "$OBJ" -o tb_sysctl
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$OBJ/tb_sysctl" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

if grep -q "SIMULATION PASSED" "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1

// File: test/tb_sysctl.sv
module tb_sysctl import sysctl_pkg::*; ();

localparam int TIMEOUT_CYC = 3000;	// tests need roughly 1200

// one expected response per accepted request
typedef struct packed {
	io_resp_t    resp;
	logic        chk;	// compare dat
	logic        lat;	// fixed 2 cycle latency expected
	logic [31:0] cyc;	// cycle of acceptance
} exp_t;

logic                 clk100;
logic                 rst;
logic                 req_valid;
logic                 req_ready;
io_req_t              req;
logic                 resp_valid;
logic                 resp_ready;
io_resp_t             resp;
logic [EXT_IRQ_W-1:0] ext_irq;
logic [LED_W-1:0]     led;
logic [NRST_W-1:0]    node_rst;
logic [CLKEN_W-1:0]   clken;
logic                 irq;

logic        req_chk;	// travel with req, sampled at acceptance
logic        req_lat;
exp_t        exp_q[$];
int          pend_cnt;	// outstanding responses, updated per edge
int          cycle;
int          err_cnt;
integer      seed;
logic        rand_ready;
logic [31:0] rd_cap;	// data of the last unchecked read

// register model
logic [LED_W-1:0]   led_m;
logic [IRQ_N-1:0]   en_m;
logic [NRST_W-1:0]  nrst_m;
logic [CLKEN_W-1:0] clken_m;

sysctl_top #(.tick_period(500)) dut_i (
	.clk100       (clk100),
	.rst          (rst),
	.req_valid_i  (req_valid),
	.req_ready_o  (req_ready),
	.req_i        (req),
	.resp_valid_o (resp_valid),
	.resp_ready_i (resp_ready),
	.resp_o       (resp),
	.ext_irq_i    (ext_irq),
	.led_o        (led),
	.node_rst_o   (node_rst),
	.clken_o      (clken),
	.irq_o        (irq)
);

always #20 clk100 = ~clk100;

// ----------------------------------------------------------------------
// reference model
// ----------------------------------------------------------------------
function automatic target_t classify_addr(input logic [ADDR_W-1:0] adr);
	if (adr[31:8] == LED_BASE[31:8])
		return TGT_LED;
	if (adr[31:8] == RST_BASE[31:8])
		return TGT_RST;
	if (adr[31:12] == IRQ_BASE[31:12])
		return TGT_IRQ;
	return TGT_NONE;
endfunction

function automatic io_resp_t ref_resp(input io_req_t r);
	io_resp_t rs;
	target_t  t;
	t      = classify_addr(r.adr);
	rs.err = (t == TGT_NONE);
	rs.dat = '0;
	if (!r.we) begin
		case (t)
			TGT_LED: rs.dat = 32'(led_m);
			TGT_RST: rs.dat = {13'b0, clken_m, nrst_m};
			TGT_IRQ: if (r.adr[11:0] == IRQ_EN_OFS) rs.dat = 32'(en_m);	// pend/cause unchecked
			default: rs.dat = '0;
		endcase
	end
	return rs;
endfunction

function automatic void model_update(input io_req_t r);
	target_t t;
	t = classify_addr(r.adr);
	if (r.we) begin
		if (t == TGT_LED && r.sel[0])
			led_m = r.dat[7:0];
		if (t == TGT_RST && |r.sel[1:0]) begin
			nrst_m = r.dat[15:0];
			if (|r.dat[5:4])
				clken_m[2] = 1'b1;	// node 2 clock woken by its reset
		end
		if (t == TGT_RST && |r.sel[3:2])
			clken_m = r.dat[18:16];
		if (t == TGT_IRQ && r.adr[11:0] == IRQ_EN_OFS)
			en_m = r.dat[7:0];
	end
endfunction

function automatic io_req_t build_req(input logic we, input logic [3:0] sel,
		input logic [31:0] adr, input logic [31:0] dat);
	io_req_t r;
	r.we  = we;
	r.sel = sel;
	r.adr = adr;
	r.dat = dat;
	return r;
endfunction

task automatic check_eq(input logic [31:0] got, input logic [31:0] expected, input string what);
	if (got !== expected) begin
		err_cnt++;
		$display("Error at time %0t: %s is %h, expected %h", $time, what, got, expected);
		$display("SIMULATION FAILED");
		$fatal(1, "stopped at first mismatch");
	end
endtask

// ----------------------------------------------------------------------
// monitor and compare
// ----------------------------------------------------------------------
always @(posedge clk100) begin
	exp_t e;
	int   pops;
	int   pushes;
	pops   = 0;
	pushes = 0;
	cycle  = cycle + 1;
	if (cycle > TIMEOUT_CYC) begin
		$display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYC);
		$display("SIMULATION FAILED");
		$fatal(1, "run aborted");
	end else if (!rst && resp_valid && resp_ready && exp_q.size() == 0) begin
		$display("A response arrived at time %0t with no request outstanding", $time);
		$display("SIMULATION FAILED");
		$fatal(1, "run aborted");
	end else begin
		if (!rst && resp_valid && resp_ready) begin
			e    = exp_q.pop_front();
			pops = 1;
			check_eq(32'(resp.err), 32'(e.resp.err), "response err");
			if (e.chk)
				check_eq(resp.dat, e.resp.dat, "response data");
			else
				rd_cap <= resp.dat;	// picked up by the stimulus
			if (e.lat)
				check_eq(cycle, e.cyc + 32'd2, "response cycle");
		end
		if (!rst && req_valid && req_ready) begin
			e.resp = ref_resp(req);	// model state before this request
			e.chk  = req_chk;
			e.lat  = req_lat;
			e.cyc  = cycle;
			exp_q.push_back(e);
			model_update(req);
			pushes = 1;
		end
		pend_cnt <= pend_cnt + pushes - pops;
	end
end

// ----------------------------------------------------------------------
// stimulus helpers
// ----------------------------------------------------------------------
task automatic step();
	logic [31:0] r;
	@(posedge clk100);
	if (rand_ready) begin
		r = $random(seed);
		resp_ready <= |r[1:0];	// ready about 3 cycles in 4
	end
endtask

task automatic send(input io_req_t r, input logic chk, input logic lat);
	req       <= r;
	req_chk   <= chk;
	req_lat   <= lat;
	req_valid <= 1'b1;
	step();
	while (!req_ready)
		step();
	req_valid <= 1'b0;	// next send overrides
endtask

task automatic wait_idle();
	step();
	while (pend_cnt != 0)
		step();
endtask

task automatic write_irq_reg(input logic [11:0] ofs, input logic [31:0] dat);
	send(build_req(1'b1, 4'hF, IRQ_BASE | 32'(ofs), dat), 1'b1, 1'b0);
endtask

task automatic read_irq_reg(input logic [11:0] ofs, output logic [31:0] val);
	send(build_req(1'b0, 4'hF, IRQ_BASE | 32'(ofs), 32'h0), 1'b0, 1'b0);
	wait_idle();
	val = rd_cap;
endtask

// ----------------------------------------------------------------------
// tests
// ----------------------------------------------------------------------
initial begin
	logic [31:0] rnd;
	logic [31:0] dat;
	logic [31:0] adr;
	logic [31:0] val;
	int          k;
	int          waited;
	clk100     = 1'b0;
	rst        = 1'b1;
	req_valid  = 1'b0;
	req        = '0;
	req_chk    = 1'b0;
	req_lat    = 1'b0;
	resp_ready = 1'b1;
	ext_irq    = '0;
	seed       = 32'h3686;
	rand_ready = 1'b0;
	pend_cnt   = 0;
	cycle      = 0;
	err_cnt    = 0;
	rd_cap     = '0;
	led_m      = '0;
	en_m       = '0;
	nrst_m     = '0;
	clken_m    = CLKEN_RESET;

	repeat (8) @(posedge clk100);
	rst <= 1'b0;
	step();
	// values right after reset
	check_eq(32'(led), 32'h0, "led_o after reset");
	check_eq(32'(node_rst), 32'h0, "node_rst_o after reset");
	check_eq(32'(irq), 32'h0, "irq_o after reset");
	check_eq(32'(clken), 32'h6, "clken_o after reset");
	check_eq(32'(resp_valid), 32'h0, "resp_valid_o after reset");
	check_eq(32'(req_ready), 32'h1, "req_ready_o after reset");

	// led writes and reads, latency checked
	for (k = 0; k < 16; k++) begin
		rnd = $random(seed);
		dat = $random(seed);
		send(build_req(1'b1, rnd[3:0], {LED_BASE[31:8], rnd[15:8]}, dat), 1'b1, 1'b1);
		send(build_req(1'b0, 4'hF, {LED_BASE[31:8], rnd[23:16]}, 32'h0), 1'b1, 1'b1);
	end
	wait_idle();
	check_eq(32'(led), 32'(led_m), "led_o");

	// mixed stream under random back-pressure
	rand_ready = 1'b1;
	for (k = 0; k < 60; k++) begin
		rnd = $random(seed);
		dat = $random(seed);
		case (rnd[1:0])
			2'd0: adr = {LED_BASE[31:8], rnd[15:8]};
			2'd1: adr = IRQ_BASE | (rnd[24] ? 32'h0C0 : 32'(IRQ_EN_OFS));	// enable or hole
			2'd2: adr = {8'h00, rnd[31:8]};
			default: adr = {24'hFD0FFE, rnd[15:8]};	// page next to the led page
		endcase
		send(build_req(rnd[2], rnd[19:16], adr, dat), 1'b1, 1'b0);
	end
	wait_idle();
	rand_ready = 1'b0;
	resp_ready <= 1'b1;

	// reset pulse length
	send(build_req(1'b1, 4'b0011, RST_BASE, 32'h0000_A5C3), 1'b1, 1'b0);
	for (k = 1; k <= RST_PULSE + 4; k++) begin
		step();
		if (k >= 2 && k <= RST_PULSE - 1)
			check_eq(32'(node_rst), 32'h0000_A5C3, "node_rst_o during pulse");
		if (k >= RST_PULSE + 2)
			check_eq(32'(node_rst), 32'h0, "node_rst_o after pulse");
	end
	nrst_m = '0;
	send(build_req(1'b1, 4'b0100, RST_BASE, 32'h0001_0000), 1'b1, 1'b0);	// clken 001
	wait_idle();
	check_eq(32'(clken), 32'h1, "clken_o from upper half");
	send(build_req(1'b1, 4'b0001, RST_BASE, 32'h0000_0010), 1'b1, 1'b0);	// bit 4
	send(build_req(1'b0, 4'hF, RST_BASE, 32'h0), 1'b1, 1'b0);
	wait_idle();
	check_eq(32'(clken), 32'h5, "clken_o bit 2 after reset of node 2");
	check_eq(32'(node_rst), 32'h10, "node_rst_o");
	repeat (RST_PULSE + 4) step();
	nrst_m = '0;
	check_eq(32'(node_rst), 32'h0, "node_rst_o after second pulse");

	// external interrupt on source 3
	write_irq_reg(IRQ_EN_OFS, 32'h08);
	write_irq_reg(IRQ_PEND_OFS, 32'hFF);
	wait_idle();
	check_eq(32'(irq), 32'h0, "irq_o with nothing pending");
	ext_irq <= 7'h08;
	step();
	ext_irq <= '0;
	step();
	step();
	check_eq(32'(irq), 32'h1, "irq_o after line 3 pulse");
	read_irq_reg(IRQ_CAUSE_OFS, val);
	check_eq(val, 32'h3, "cause for line 3");
	write_irq_reg(IRQ_PEND_OFS, 32'h08);
	wait_idle();
	check_eq(32'(irq), 32'h0, "irq_o after clear");
	read_irq_reg(IRQ_PEND_OFS, val);
	check_eq(32'(val[3]), 32'h0, "pending bit 3 after clear");

	// timer source
	write_irq_reg(IRQ_EN_OFS, 32'h88);
	write_irq_reg(IRQ_PEND_OFS, 32'hFF);
	wait_idle();
	waited = 0;
	while (!irq && waited < 600) begin
		step();
		waited++;
	end
	check_eq(32'(irq), 32'h1, "irq_o from timer within 600 cycles");
	read_irq_reg(IRQ_PEND_OFS, val);
	check_eq(32'(val[TICK_SRC]), 32'h1, "timer pending bit");
	ext_irq <= 7'h08;	// lower source also pending
	step();
	ext_irq <= '0;
	step();
	read_irq_reg(IRQ_CAUSE_OFS, val);
	check_eq(val, 32'(TICK_SRC), "cause with timer highest");

	wait_idle();
	if (err_cnt == 0) begin
		$display("SIMULATION PASSED");
	end else begin
		$display("SIMULATION FAILED");
	end
	$finish;
end

endmodule

// File: hw/sysctl_top.sv
module sysctl_top import sysctl_pkg::*; #(
	parameter int tick_period = TICK_PERIOD
) (
	input  logic                 clk100,
	input  logic                 rst,
	input  logic                 req_valid_i,
	output logic                 req_ready_o,
	input  io_req_t              req_i,
	output logic                 resp_valid_o,
	input  logic                 resp_ready_i,
	output io_resp_t             resp_o,
	input  logic [EXT_IRQ_W-1:0] ext_irq_i,
	output logic [LED_W-1:0]     led_o,
	output logic [NRST_W-1:0]    node_rst_o,
	output logic [CLKEN_W-1:0]   clken_o,
	output logic                 irq_o
);

logic              dec_valid;
logic              dec_ready;
dec_req_t          dec;
logic              acc;
logic [DATA_W-1:0] regs_rdat;	// led and reset share one read port
logic [DATA_W-1:0] irq_rdat;
logic              tick;

// ---------------------------------------------------------------------
// request side
// ---------------------------------------------------------------------
sysctl_decode u_decode (
	.clk100      (clk100),
	.rst         (rst),
	.req_valid_i (req_valid_i),
	.req_ready_o (req_ready_o),
	.req_i       (req_i),
	.dec_ready_i (dec_ready),
	.dec_valid_o (dec_valid),
	.dec_o       (dec)
);

sysctl_regs u_regs (
	.clk100     (clk100),
	.rst        (rst),
	.acc_i      (acc),
	.dec_i      (dec),
	.rdat_o     (regs_rdat),
	.led_o      (led_o),
	.node_rst_o (node_rst_o),
	.clken_o    (clken_o)
);

tick_timer #(.period(tick_period)) u_tick (
	.clk100 (clk100),
	.rst    (rst),
	.tick_o (tick)
);

irq_ctrl u_irq (
	.clk100    (clk100),
	.rst       (rst),
	.acc_i     (acc),
	.dec_i     (dec),
	.ext_irq_i (ext_irq_i),
	.tick_i    (tick),
	.rdat_o    (irq_rdat),
	.irq_o     (irq_o)
);

// ---------------------------------------------------------------------
// response side
// ---------------------------------------------------------------------
resp_merge u_merge (
	.clk100       (clk100),
	.rst          (rst),
	.dec_valid_i  (dec_valid),
	.dec_i        (dec),
	.led_rdat_i   (regs_rdat),
	.rst_rdat_i   (regs_rdat),
	.irq_rdat_i   (irq_rdat),
	.acc_o        (acc),
	.dec_ready_o  (dec_ready),
	.resp_valid_o (resp_valid_o),
	.resp_ready_i (resp_ready_i),
	.resp_o       (resp_o)
);

endmodule

// File: hw/resp_merge.sv
module resp_merge import sysctl_pkg::*; (
	input  logic              clk100,
	input  logic              rst,
	input  logic              dec_valid_i,
	input  dec_req_t          dec_i,
	input  logic [DATA_W-1:0] led_rdat_i,
	input  logic [DATA_W-1:0] rst_rdat_i,
	input  logic [DATA_W-1:0] irq_rdat_i,
	output logic              acc_o,
	output logic              dec_ready_o,
	output logic              resp_valid_o,
	input  logic              resp_ready_i,
	output io_resp_t          resp_o
);

logic [DATA_W-1:0] rd_sel;
io_resp_t          resp_d;

// ---------------------------------------------------------------------
// response mux
// ---------------------------------------------------------------------
always_comb begin
	case (dec_i.tgt)
		TGT_LED: rd_sel = led_rdat_i;
		TGT_RST: rd_sel = rst_rdat_i;
		TGT_IRQ: rd_sel = irq_rdat_i;
		default: rd_sel = '0;
	endcase
	resp_d.err = (dec_i.tgt == TGT_NONE);
	resp_d.dat = (dec_i.req.we || resp_d.err) ? '0 : rd_sel;	// writes and errors read 0
end

assign dec_ready_o = ~resp_valid_o | resp_ready_i;	// slot free or leaving
assign acc_o       = dec_valid_i & dec_ready_o;	// the one access strobe

always_ff @(posedge clk100) begin
	if (rst)
		resp_valid_o <= 1'b0;
	else if (acc_o)
		resp_valid_o <= 1'b1;
	else if (resp_ready_i)
		resp_valid_o <= 1'b0;
end

// held stable while the master stalls
always_ff @(posedge clk100) begin
	if (acc_o)
		resp_o <= resp_d;
end

endmodule

// File: hw/irq_ctrl.sv
module irq_ctrl import sysctl_pkg::*; (
	input  logic                 clk100,
	input  logic                 rst,
	input  logic                 acc_i,
	input  dec_req_t             dec_i,
	input  logic [EXT_IRQ_W-1:0] ext_irq_i,
	input  logic                 tick_i,
	output logic [DATA_W-1:0]    rdat_o,
	output logic                 irq_o
);

logic [IRQ_N-1:0]     src;	// level per source this cycle
logic [IRQ_N-1:0]     pend;
logic [IRQ_N-1:0]     en;
logic [IRQ_N-1:0]     act;	// pending and enabled
logic [IRQ_N-1:0]     clr;
logic [IRQ_OFS_W-1:0] ofs;
logic                 irq_wr;
logic [CAUSE_W-1:0]   cause;

always_comb begin
	src                  = '0;
	src[EXT_IRQ_W-1:0]   = ext_irq_i;
	src[TICK_SRC]        = tick_i;
end

assign ofs    = dec_i.req.adr[IRQ_OFS_W-1:0];
assign irq_wr = acc_i & dec_i.req.we & (dec_i.tgt == TGT_IRQ);
assign clr    = (irq_wr && ofs == IRQ_PEND_OFS) ? dec_i.req.dat[IRQ_N-1:0] : '0;

// ---------------------------------------------------------------------
// pending and enable
// ---------------------------------------------------------------------
always_ff @(posedge clk100) begin
	if (rst) begin
		pend <= '0;
		en   <= '0;
	end else begin
		pend <= (pend & ~clr) | src;	// new set beats write-1 clear
		if (irq_wr && ofs == IRQ_EN_OFS)
			en <= dec_i.req.dat[IRQ_N-1:0];
	end
end

assign act   = pend & en;
assign irq_o = |act;

// highest numbered active source
always_comb begin
	cause = CAUSE_NONE;
	for (int i = 0; i < IRQ_N; i++)
		if (act[i])
			cause = CAUSE_W'(i);	// later index overrides
end

always_comb begin
	rdat_o = '0;
	if (dec_i.tgt == TGT_IRQ) begin
		case (ofs)
			IRQ_PEND_OFS:  rdat_o[IRQ_N-1:0]   = pend;
			IRQ_EN_OFS:    rdat_o[IRQ_N-1:0]   = en;
			IRQ_CAUSE_OFS: rdat_o[CAUSE_W-1:0] = cause;
			default:       rdat_o              = '0;	// hole in the block
		endcase
	end
end

endmodule

// File: hw/tick_timer.sv
module tick_timer import sysctl_pkg::*; #(
	parameter int period = TICK_PERIOD	// must fit TICK_CNT_W bits
) (
	input  logic clk100,
	input  logic rst,
	output logic tick_o
);

logic [TICK_CNT_W-1:0] cnt;
logic                  wrap;

// ---------------------------------------------------------------------
// free running divider
// ---------------------------------------------------------------------
assign wrap = (cnt == TICK_CNT_W'(period - 1));

always_ff @(posedge clk100) begin
	if (rst) begin
		cnt    <= '0;
		tick_o <= 1'b0;
	end else begin
		tick_o <= wrap;	// one cycle per wrap
		if (wrap)
			cnt <= '0;
		else
			cnt <= cnt + TICK_CNT_W'(1);
	end
end

// first tick lands period cycles after reset
// since cnt starts at zero and tick is registered

endmodule

// File: hw/sysctl_regs.sv
module sysctl_regs import sysctl_pkg::*; (
	input  logic               clk100,
	input  logic               rst,
	input  logic               acc_i,
	input  dec_req_t           dec_i,
	output logic [DATA_W-1:0]  rdat_o,
	output logic [LED_W-1:0]   led_o,
	output logic [NRST_W-1:0]  node_rst_o,
	output logic [CLKEN_W-1:0] clken_o
);

logic                 wr;
logic                 led_wr;
logic                 rst_wr;
logic                 rst_lo;	// lower half, reset bits
logic                 rst_hi;	// upper half, clock enables
logic [RST_CNT_W-1:0] pulse_cnt;
logic                 pulse_end;

always_comb begin
	wr     = acc_i & dec_i.req.we;
	led_wr = wr & (dec_i.tgt == TGT_LED) & dec_i.req.sel[0];	// byte 0 only
	rst_wr = wr & (dec_i.tgt == TGT_RST);
	rst_lo = rst_wr & (|dec_i.req.sel[1:0]);
	rst_hi = rst_wr & (|dec_i.req.sel[3:2]);
end

assign pulse_end = (pulse_cnt == RST_CNT_W'(RST_PULSE - 1));

// ---------------------------------------------------------------------
// led register
// ---------------------------------------------------------------------
always_ff @(posedge clk100) begin
	if (rst)
		led_o <= '0;
	else if (led_wr)
		led_o <= dec_i.req.dat[LED_W-1:0];
end

// ---------------------------------------------------------------------
// node reset pulse and clock enables
// ---------------------------------------------------------------------
always_ff @(posedge clk100) begin
	if (rst) begin
		node_rst_o <= '0;
		pulse_cnt  <= RST_CNT_W'(RST_PULSE - 1);	// parked, nothing pending
		clken_o    <= CLKEN_RESET;
	end else begin
		if (!pulse_end)
			pulse_cnt <= pulse_cnt + RST_CNT_W'(1);
		else
			node_rst_o <= '0;	// pulse over, release the nodes
		if (rst_lo) begin
			node_rst_o <= dec_i.req.dat[NRST_W-1:0];
			pulse_cnt  <= '0;	// restart pulse
			// resetting node 2 also wakes its clock
			if (|dec_i.req.dat[5:4])
				clken_o[2] <= 1'b1;
		end
		if (rst_hi)
			clken_o <= dec_i.req.dat[NRST_W +: CLKEN_W];	// upper half wins
	end
end

// read back, only for our own targets
always_comb begin
	rdat_o = '0;
	case (dec_i.tgt)
		TGT_LED: rdat_o[LED_W-1:0] = led_o;
		TGT_RST: begin
			rdat_o[NRST_W-1:0]       = node_rst_o;
			rdat_o[NRST_W +: CLKEN_W] = clken_o;
		end
		default: rdat_o = '0;
	endcase
end

endmodule

// File: hw/sysctl_decode.sv
module sysctl_decode import sysctl_pkg::*; (
	input  logic     clk100,
	input  logic     rst,
	input  logic     req_valid_i,
	output logic     req_ready_o,
	input  io_req_t  req_i,
	input  logic     dec_ready_i,
	output logic     dec_valid_o,
	output dec_req_t dec_o
);

logic     skid_valid;	// skid entry holds a request
dec_req_t skid_q;
dec_req_t req_dec;	// incoming request with its target
logic     in_fire;
logic     main_load;	// main entry empty or draining

// compare against the page / block bases
function automatic target_t decode_tgt(input logic [ADDR_W-1:0] adr);
	if (adr[ADDR_W-1:PAGE_LSB] == LED_BASE[ADDR_W-1:PAGE_LSB])
		return TGT_LED;
	if (adr[ADDR_W-1:PAGE_LSB] == RST_BASE[ADDR_W-1:PAGE_LSB])
		return TGT_RST;
	if (adr[ADDR_W-1:IRQ_OFS_W] == IRQ_BASE[ADDR_W-1:IRQ_OFS_W])
		return TGT_IRQ;
	return TGT_NONE;	// bus error stand-in
endfunction

always_comb begin
	req_dec.req = req_i;
	req_dec.tgt = decode_tgt(req_i.adr);
end

assign req_ready_o = ~skid_valid;	// registered ready, no path from resp_ready
assign in_fire     = req_valid_i & req_ready_o;
assign main_load   = ~dec_valid_o | dec_ready_i;

// ---------------------------------------------------------------------
// control
// ---------------------------------------------------------------------
always_ff @(posedge clk100) begin
	if (rst) begin
		dec_valid_o <= 1'b0;
		skid_valid  <= 1'b0;
	end else if (main_load) begin
		// skid first, keeps order; in_fire is low while skid is full
		dec_valid_o <= skid_valid | in_fire;
		skid_valid  <= 1'b0;
	end else if (in_fire) begin
		skid_valid <= 1'b1;	// main stalled, park it
	end
end

// ---------------------------------------------------------------------
// payload
// ---------------------------------------------------------------------
always_ff @(posedge clk100) begin
	if (main_load) begin
		if (skid_valid)
			dec_o <= skid_q;
		else if (in_fire)
			dec_o <= req_dec;
	end else if (in_fire) begin
		skid_q <= req_dec;
	end
end

endmodule

// File: hw/sysctl_pkg.sv
package sysctl_pkg;

// ---------------------------------------------------------------------
// bus and register widths
// ---------------------------------------------------------------------
localparam int ADDR_W    = 32;
localparam int DATA_W    = 32;
localparam int SEL_W     = 4;	// one bit per byte lane
localparam int LED_W     = 8;
localparam int NRST_W    = 16;	// node reset bits, also lsb of clken in the reset reg
localparam int CLKEN_W   = 3;
localparam int IRQ_N     = 8;
localparam int EXT_IRQ_W = 7;	// sources 0..6
localparam int CAUSE_W   = 8;

// ---------------------------------------------------------------------
// sources and timing
// ---------------------------------------------------------------------
localparam int TICK_SRC    = 7;	// timer takes the top source
localparam int RST_PULSE   = 64;	// cycles a node reset stays asserted
localparam int RST_CNT_W   = $clog2(RST_PULSE);
localparam int TICK_PERIOD = 1_000_000;	// 100 Hz at 100 MHz
localparam int TICK_CNT_W  = $clog2(TICK_PERIOD);
localparam logic [CLKEN_W-1:0] CLKEN_RESET = 3'b110;	// nodes 1 and 2 running
localparam logic [CAUSE_W-1:0] CAUSE_NONE  = 8'hFF;

// ---------------------------------------------------------------------
// address map
// ---------------------------------------------------------------------
localparam logic [ADDR_W-1:0] LED_BASE = 32'hFD0F_FF00;	// 256 byte page
localparam logic [ADDR_W-1:0] RST_BASE = 32'hFD0F_FC00;	// 256 byte page
localparam logic [ADDR_W-1:0] IRQ_BASE = 32'hFD09_0000;	// 4 KB block
localparam int PAGE_LSB  = 8;
localparam int IRQ_OFS_W = 12;	// offset bits inside the irq block

localparam logic [IRQ_OFS_W-1:0] IRQ_PEND_OFS  = 12'h000;
localparam logic [IRQ_OFS_W-1:0] IRQ_EN_OFS    = 12'h004;
localparam logic [IRQ_OFS_W-1:0] IRQ_CAUSE_OFS = 12'h008;

// decoded target of a request
typedef enum logic [1:0] {
	TGT_NONE,	// unmapped, answered with err
	TGT_LED,
	TGT_RST,
	TGT_IRQ
} target_t;

typedef struct packed {
	logic              we;
	logic [SEL_W-1:0]  sel;
	logic [ADDR_W-1:0] adr;
	logic [DATA_W-1:0] dat;
} io_req_t;

// request as held in the decode stage
typedef struct packed {
	io_req_t req;
	target_t tgt;
} dec_req_t;

typedef struct packed {
	logic [DATA_W-1:0] dat;
	logic              err;
} io_resp_t;

endpackage
